/* files.f */
+incdir+include
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/alu.sv
hw/reg_file.sv
hw/pipe_controller.sv
hw/word_ram.sv
hw/cpu_core.sv
hw/cpu_top.sv
verif/cpu_tb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module cpu_tb -f files.f -o cpu_sim \
   && ./obj_dir/cpu_sim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0

/* include/cpu_asm.svh */
`ifndef CPU_ASM_SVH
`define CPU_ASM_SVH

// Fields op[15:14] ra[13:11] rb[10:8] d[7:0]
// ALU function sits in d[7:4]

function automatic isa_pkg::word_t load_word(isa_pkg::reg_idx_t dst, isa_pkg::reg_idx_t base,
                                             logic [7:0] off);
   return {isa_pkg::OP_LD, dst, base, off};
endfunction

function automatic isa_pkg::word_t store_word(isa_pkg::reg_idx_t src, isa_pkg::reg_idx_t base,
                                              logic [7:0] off);
   return {isa_pkg::OP_ST, src, base, off};
endfunction

function automatic isa_pkg::word_t load_imm(isa_pkg::reg_idx_t dst, logic [7:0] val);
   return {isa_pkg::OP_IMM, 3'd0, dst, val};
endfunction

function automatic isa_pkg::word_t branch(logic [7:0] off);
   return {isa_pkg::OP_IMM, 3'd4, 3'd0, off};   // Target is next pc plus off
endfunction

function automatic isa_pkg::word_t branch_if(isa_pkg::cond_e cond, logic [7:0] off);
   logic [2:0] code;
   case (cond)
      isa_pkg::COND_BE:  code = 3'd0;
      isa_pkg::COND_BLT: code = 3'd1;
      isa_pkg::COND_BLE: code = 3'd2;
      isa_pkg::COND_BNE: code = 3'd3;
      default:           code = 3'd7;
   endcase
   return {isa_pkg::OP_IMM, 3'd7, code, off};
endfunction

// dst becomes dst op src
// CMP only sets flags from dst minus src
function automatic isa_pkg::word_t alu_rr(isa_pkg::alu_fn_e fn, isa_pkg::reg_idx_t dst,
                                          isa_pkg::reg_idx_t src);
   return {isa_pkg::OP_ALU, src, dst, fn, 4'd0};
endfunction

function automatic isa_pkg::word_t shift_imm(isa_pkg::alu_fn_e fn, isa_pkg::reg_idx_t dst,
                                             logic [3:0] amt);
   return {isa_pkg::OP_ALU, 3'd0, dst, fn, amt};
endfunction

function automatic isa_pkg::word_t out_reg(isa_pkg::reg_idx_t r);
   return {isa_pkg::OP_ALU, 3'd0, r, isa_pkg::FN_OUT, 4'd0};
endfunction

function automatic isa_pkg::word_t halt_cpu();
   return {isa_pkg::OP_ALU, 3'd0, 3'd0, isa_pkg::FN_HLT, 4'd0};
endfunction

`endif

/* verif/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;

   localparam int CYCLE_LIMIT = 6 * 400;   // Six tests, 400 cycles each

   logic                       clk;
   logic                       rst_n;
   logic                       prog_we;
   logic [isa_pkg::ADDR_W-1:0] prog_addr;
   isa_pkg::word_t             prog_data;
   logic                       out_valid;
   isa_pkg::word_t             out_data;
   logic                       halted;

   isa_pkg::word_t prog[$];
   isa_pkg::word_t exp_q[$];
   isa_pkg::word_t got_q[$];
   int             errors;
   int             checks;
   int             cycles;

   `include "cpu_asm.svh"

   cpu_top dut (
      .clk(clk), .rst_n(rst_n), .prog_we(prog_we), .prog_addr(prog_addr),
      .prog_data(prog_data), .out_valid(out_valid), .out_data(out_data), .halted(halted));

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(negedge clk) begin
      if (rst_n && out_valid)
         got_q.push_back(out_data);
   end

   initial begin
      cycles = 0;
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      $display("ERROR: run exceeded %0d cycles, a program did not halt", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
   end

   function automatic isa_pkg::word_t sign_extend(logic [7:0] d);
      return {{8{d[7]}}, d};
   endfunction

   task automatic after_edge();
      @(posedge clk);
      #2;
   endtask

   task automatic check_word(string name, isa_pkg::word_t got, isa_pkg::word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
      end
   endtask

   task automatic check_count(string name, int got, int exp);
      checks++;
      if (got != exp) begin
         errors++;
         $display("MISMATCH t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
      end
   endtask

   task automatic check_flag(string name, logic got, logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH t=%0t %s got=%b exp=%b", $time, name, got, exp);
      end
   endtask

   // Load while in reset, release, wait for halt, compare the OUT stream
   task automatic run_program(string name);
      after_edge();
      rst_n = 1'b0;
      foreach (prog[i]) begin
         after_edge();
         prog_we   = 1'b1;
         prog_addr = isa_pkg::ADDR_W'(i);
         prog_data = prog[i];
      end
      after_edge();
      prog_we = 1'b0;
      repeat (8) after_edge();
      got_q.delete();
      rst_n = 1'b1;
      while (!halted)
         @(negedge clk);
      repeat (4) @(negedge clk);
      check_count({name, " output count"}, got_q.size(), exp_q.size());
      for (int i = 0; i < exp_q.size() && i < got_q.size(); i++)
         check_word($sformatf("%s out_data[%0d]", name, i), got_q[i], exp_q[i]);
   endtask

   task automatic alu_test();
      isa_pkg::alu_fn_e  fns[5];
      isa_pkg::reg_idx_t dst;
      isa_pkg::word_t    a;
      isa_pkg::word_t    b;
      isa_pkg::word_t    r;
      logic [7:0]        a8;
      logic [7:0]        b8;
      fns = '{isa_pkg::FN_ADD, isa_pkg::FN_SUB, isa_pkg::FN_AND, isa_pkg::FN_OR,
              isa_pkg::FN_XOR};
      a8 = 8'($urandom);
      b8 = 8'($urandom);
      a  = sign_extend(a8);
      b  = sign_extend(b8);
      prog.delete();
      exp_q.delete();
      prog.push_back(load_imm(3'd1, a8));
      prog.push_back(load_imm(3'd2, b8));
      for (int i = 0; i < 5; i++) begin
         dst = isa_pkg::reg_idx_t'(3 + i);
         prog.push_back(alu_rr(isa_pkg::FN_MOV, dst, 3'd1));
         prog.push_back(alu_rr(fns[i], dst, 3'd2));
         prog.push_back(out_reg(dst));
         case (fns[i])
            isa_pkg::FN_ADD: r = a + b;
            isa_pkg::FN_SUB: r = a - b;
            isa_pkg::FN_AND: r = a & b;
            isa_pkg::FN_OR:  r = a | b;
            default:         r = a ^ b;
         endcase
         exp_q.push_back(r);
      end
      prog.push_back(alu_rr(isa_pkg::FN_MOV, 3'd0, 3'd2));
      prog.push_back(out_reg(3'd0));
      exp_q.push_back(b);
      prog.push_back(halt_cpu());
      run_program("alu");
   endtask

   task automatic chain_test();
      isa_pkg::word_t sum;
      logic [7:0]     v8;
      sum = '0;
      prog.delete();
      exp_q.delete();
      prog.push_back(load_imm(3'd2, 8'h00));
      for (int k = 0; k < 6; k++) begin
         v8 = 8'($urandom);
         sum = sum + sign_extend(v8);
         prog.push_back(load_imm(3'd1, v8));
         prog.push_back(alu_rr(isa_pkg::FN_ADD, 3'd2, 3'd1));
         prog.push_back(out_reg(3'd2));
         exp_q.push_back(sum);
      end
      prog.push_back(alu_rr(isa_pkg::FN_ADD, 3'd2, 3'd2));   // Reads its own result
      prog.push_back(out_reg(3'd2));
      exp_q.push_back(sum + sum);
      prog.push_back(halt_cpu());
      run_program("chain");
   endtask

   task automatic mem_test();
      logic [7:0] base8;
      logic [7:0] offs[4];
      logic [7:0] vals[4];
      base8 = 8'($urandom % 64);
      for (int i = 0; i < 4; i++) begin
         offs[i] = 8'(i * 4 + $urandom % 4);
         vals[i] = 8'($urandom);
      end
      prog.delete();
      exp_q.delete();
      prog.push_back(load_imm(3'd1, base8));
      prog.push_back(load_imm(3'd4, ~vals[0]));
      for (int i = 0; i < 4; i++) begin
         prog.push_back(load_imm(3'd2, vals[i]));
         prog.push_back(store_word(3'd2, 3'd1, offs[i]));
      end
      prog.push_back(branch(8'd1));
      prog.push_back(store_word(3'd4, 3'd1, offs[0]));   // Skipped, must leave memory alone
      for (int i = 3; i >= 0; i--) begin
         prog.push_back(load_word(3'd3, 3'd1, offs[i]));
         prog.push_back(out_reg(3'd3));   // Uses the load at once
         exp_q.push_back(sign_extend(vals[i]));
      end
      prog.push_back(halt_cpu());
      run_program("memory");
   endtask

   task automatic shift_test();
      isa_pkg::alu_fn_e  fns[4];
      isa_pkg::reg_idx_t dst;
      isa_pkg::word_t    v;
      isa_pkg::word_t    r;
      logic [7:0]        hi8;
      logic [7:0]        lo8;
      logic [3:0]        amt;
      fns = '{isa_pkg::FN_SLL, isa_pkg::FN_SLR, isa_pkg::FN_SRL, isa_pkg::FN_SRA};
      hi8 = 8'($urandom);
      lo8 = 8'($urandom % 128);
      v   = (sign_extend(hi8) << 8) | {8'h00, lo8};
      prog.delete();
      exp_q.delete();
      prog.push_back(load_imm(3'd1, hi8));
      prog.push_back(shift_imm(isa_pkg::FN_SLL, 3'd1, 4'd8));
      prog.push_back(load_imm(3'd6, lo8));
      prog.push_back(alu_rr(isa_pkg::FN_OR, 3'd1, 3'd6));
      for (int i = 0; i < 4; i++) begin
         dst = isa_pkg::reg_idx_t'(2 + i);
         amt = 4'($urandom % 15 + 1);
         prog.push_back(alu_rr(isa_pkg::FN_MOV, dst, 3'd1));
         prog.push_back(shift_imm(fns[i], dst, amt));
         prog.push_back(out_reg(dst));
         case (fns[i])
            isa_pkg::FN_SLL: r = v << amt;
            isa_pkg::FN_SLR: r = 16'({v, v} >> (16 - amt));   // Rotate left
            isa_pkg::FN_SRL: r = v >> amt;
            default:         r = $signed(v) >>> amt;
         endcase
         exp_q.push_back(r);
      end
      prog.push_back(halt_cpu());
      run_program("shift");
   endtask

   task automatic branch_test();
      isa_pkg::cond_e    conds[4];
      isa_pkg::reg_idx_t lhs[3];
      isa_pkg::reg_idx_t rhs[3];
      isa_pkg::word_t    p;
      isa_pkg::word_t    q;
      logic [7:0]        x8;
      logic [7:0]        y8;
      logic              taken;
      conds = '{isa_pkg::COND_BE, isa_pkg::COND_BLT, isa_pkg::COND_BLE, isa_pkg::COND_BNE};
      lhs   = '{3'd1, 3'd1, 3'd2};
      rhs   = '{3'd1, 3'd2, 3'd1};
      x8 = 8'($urandom % 64 + 64);    // Large positive upper byte
      y8 = 8'($urandom % 64 + 128);   // Large negative, so CMP overflows
      prog.delete();
      exp_q.delete();
      prog.push_back(load_imm(3'd1, x8));
      prog.push_back(shift_imm(isa_pkg::FN_SLL, 3'd1, 4'd8));
      prog.push_back(load_imm(3'd2, y8));
      prog.push_back(shift_imm(isa_pkg::FN_SLL, 3'd2, 4'd8));
      for (int r = 3; r < 8; r++)
         prog.push_back(load_imm(isa_pkg::reg_idx_t'(r), 8'(8'h10 + r)));   // Markers
      for (int n = 0; n < 3; n++) begin
         p = (lhs[n] == 3'd1) ? {x8, 8'h00} : {y8, 8'h00};
         q = (rhs[n] == 3'd1) ? {x8, 8'h00} : {y8, 8'h00};
         prog.push_back(alu_rr(isa_pkg::FN_CMP, lhs[n], rhs[n]));
         for (int k = 0; k < 4; k++) begin
            case (conds[k])
               isa_pkg::COND_BE:  taken = (p == q);
               isa_pkg::COND_BLT: taken = ($signed(p) < $signed(q));
               isa_pkg::COND_BLE: taken = ($signed(p) <= $signed(q));
               default:           taken = (p != q);
            endcase
            prog.push_back(branch_if(conds[k], 8'd1));   // Skips one OUT
            prog.push_back(out_reg(isa_pkg::reg_idx_t'(3 + k)));
            if (!taken)
               exp_q.push_back(sign_extend(8'(8'h13 + k)));
         end
      end
      prog.push_back(branch(8'd1));
      prog.push_back(out_reg(3'd7));
      prog.push_back(out_reg(3'd3));
      exp_q.push_back(16'h0013);
      prog.push_back(halt_cpu());
      run_program("branch");
   endtask

   task automatic halt_test();
      logic [7:0] v8;
      v8 = 8'($urandom);
      prog.delete();
      exp_q.delete();
      prog.push_back(load_imm(3'd1, v8));
      prog.push_back(out_reg(3'd1));
      prog.push_back(halt_cpu());
      prog.push_back(out_reg(3'd1));
      prog.push_back(load_imm(3'd1, 8'h00));
      prog.push_back(out_reg(3'd1));
      exp_q.push_back(sign_extend(v8));
      run_program("halt");
      check_flag("halted", halted, 1'b1);
      repeat (8) @(negedge clk);
      check_flag("halted after idle cycles", halted, 1'b1);
      check_count("outputs after halt", got_q.size(), 1);
      after_edge();
      rst_n = 1'b0;
      repeat (2) @(negedge clk);
      check_flag("halted in reset", halted, 1'b0);
      check_flag("out_valid in reset", out_valid, 1'b0);
   endtask

   initial begin
      rst_n     = 1'b0;
      prog_we   = 1'b0;
      prog_addr = '0;
      prog_data = '0;
      errors    = 0;
      checks    = 0;
      void'($urandom(49492));
      alu_test();
      chain_test();
      mem_test();
      shift_test();
      branch_test();
      halt_test();
      $display("checks=%0d errors=%0d", checks, errors);
      if (errors == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

/* hw/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       prog_we,
   input  logic [isa_pkg::ADDR_W-1:0] prog_addr,
   input  isa_pkg::word_t             prog_data,
   output logic                       out_valid,
   output isa_pkg::word_t             out_data,
   output logic                       halted
);

   logic [isa_pkg::ADDR_W-1:0] imem_addr;
   logic [isa_pkg::ADDR_W-1:0] dmem_addr;
   isa_pkg::word_t             imem_data;
   isa_pkg::word_t             dmem_rdata;
   isa_pkg::word_t             dmem_wdata;
   logic                       dmem_we;

   cpu_core u_core (
      .clk(clk), .rst_n(rst_n), .imem_data(imem_data), .dmem_rdata(dmem_rdata),
      .imem_addr(imem_addr), .dmem_addr(dmem_addr), .dmem_we(dmem_we),
      .dmem_wdata(dmem_wdata), .out_valid(out_valid), .out_data(out_data),
      .halted(halted));

   // Write port doubles as the program loader
   word_ram imem (
      .clk(clk), .we(prog_we), .wr_addr(prog_addr), .wr_data(prog_data),
      .rd_addr(imem_addr), .rd_data(imem_data));

   word_ram dmem (
      .clk(clk), .we(dmem_we), .wr_addr(dmem_addr), .wr_data(dmem_wdata),
      .rd_addr(dmem_addr), .rd_data(dmem_rdata));

endmodule

/* hw/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core (
   input  logic                       clk,
   input  logic                       rst_n,
   input  isa_pkg::word_t             imem_data,
   input  isa_pkg::word_t             dmem_rdata,
   output logic [isa_pkg::ADDR_W-1:0] imem_addr,
   output logic [isa_pkg::ADDR_W-1:0] dmem_addr,
   output logic                       dmem_we,
   output isa_pkg::word_t             dmem_wdata,
   output logic                       out_valid,
   output isa_pkg::word_t             out_data,
   output logic                       halted
);

   pipe_pkg::ifid_t   ifid_q, id_s;
   pipe_pkg::idex_t   idex_q;
   pipe_pkg::exmem_t  exmem_q;
   pipe_pkg::memwb_t  memwb_q, wb_s;
   pipe_pkg::ctrl_t   ctrl_id;
   isa_pkg::word_t    pc_q, rd_a, rd_b, imm_id, alu_a, alu_b, alu_y, ex_result, wb_data;
   isa_pkg::flags_t   alu_flags, flags_q;
   isa_pkg::reg_idx_t dest_id;
   isa_pkg::cond_e    wb_cond;
   logic [isa_pkg::NUM_REGS-1:0] pending;
   logic en_ifid, flush_ifid, en_idex, flush_idex, en_exmem, flush_exmem;
   logic en_memwb, flush_memwb, pc_en, take_branch, wb_we, mark_en;

   // Instruction word arrives from imem in the ID cycle
   assign id_s    = '{valid: ifid_q.valid, pc: ifid_q.pc, inst: imem_data};
   assign wb_s    = '{valid: memwb_q.valid, ctrl: memwb_q.ctrl, result: memwb_q.result,
                      ld_data: dmem_rdata, dest: memwb_q.dest, flags: memwb_q.flags};
   assign imm_id  = {{8{id_s.inst[7]}}, id_s.inst[7:0]};
   assign dest_id = ctrl_id.dest_is_ra ? id_s.inst[13:11] : id_s.inst[10:8];
   assign wb_cond = (wb_s.valid && !halted) ? wb_s.ctrl.cond : isa_pkg::COND_NONE;
   assign imem_addr = (en_ifid && !halted) ? pc_q[7:0] : ifid_q.pc[7:0];   // Refetch on hold
   assign mark_en = ctrl_id.reg_we && en_idex && !flush_idex && !halted;

   pipe_controller u_ctrl (
      .inst(id_s.inst), .id_valid(id_s.valid), .pending(pending), .wb_cond(wb_cond),
      .flags(flags_q), .ctrl(ctrl_id), .en_ifid(en_ifid), .flush_ifid(flush_ifid),
      .en_idex(en_idex), .flush_idex(flush_idex), .en_exmem(en_exmem),
      .flush_exmem(flush_exmem), .en_memwb(en_memwb), .flush_memwb(flush_memwb),
      .pc_en(pc_en), .take_branch(take_branch));

   reg_file u_rf (
      .clk(clk), .rst_n(rst_n), .flush_all(take_branch),
      .rd_a_idx(id_s.inst[10:8]), .rd_b_idx(id_s.inst[13:11]),
      .we(wb_we), .wr_idx(wb_s.dest), .wr_data(wb_data),
      .mark_en(mark_en), .mark_idx(dest_id),
      .rd_a(rd_a), .rd_b(rd_b), .pending(pending));

   always_comb begin
      case (idex_q.ctrl.src_a)
         pipe_pkg::A_REG_RB: alu_a = idex_q.op_a;
         pipe_pkg::A_PC:     alu_a = idex_q.pc;
         default:            alu_a = '0;
      endcase
      case (idex_q.ctrl.src_b)
         pipe_pkg::B_REG_RA: alu_b = idex_q.op_b;
         pipe_pkg::B_SHAMT:  alu_b = {12'd0, idex_q.imm[3:0]};
         pipe_pkg::B_IMM:    alu_b = idex_q.imm;
         default:            alu_b = 16'd1;
      endcase
      case (idex_q.ctrl.wb_sel)
         pipe_pkg::WB_PASS_A: ex_result = alu_a;
         pipe_pkg::WB_IMM:    ex_result = idex_q.imm;
         default:             ex_result = alu_y;
      endcase
   end

   alu u_alu (.fn(idex_q.ctrl.alu_fn), .a(alu_a), .b(alu_b), .y(alu_y), .flags(alu_flags));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc_q          <= '0;
         ifid_q.valid  <= 1'b0;
         idex_q.valid  <= 1'b0;
         exmem_q.valid <= 1'b0;
         memwb_q.valid <= 1'b0;
      end else if (!halted) begin
         if (take_branch)
            pc_q <= wb_s.result;   // Target from EX
         else if (pc_en)
            pc_q <= pc_q + 16'd1;
         if (flush_ifid)
            ifid_q.valid <= 1'b0;
         else if (en_ifid)
            ifid_q <= '{valid: 1'b1, pc: pc_q, inst: '0};
         if (flush_idex)
            idex_q.valid <= 1'b0;
         else if (en_idex)
            idex_q <= '{valid: id_s.valid, pc: id_s.pc + 16'd1, ctrl: ctrl_id,
                        op_a: rd_a, op_b: rd_b, imm: imm_id, dest: dest_id};
         if (flush_exmem)
            exmem_q.valid <= 1'b0;
         else if (en_exmem)
            exmem_q <= '{valid: idex_q.valid, ctrl: idex_q.ctrl, result: ex_result,
                         store_data: idex_q.op_b, dest: idex_q.dest, flags: alu_flags};
         if (flush_memwb)
            memwb_q.valid <= 1'b0;
         else if (en_memwb)
            memwb_q <= '{valid: exmem_q.valid, ctrl: exmem_q.ctrl, result: exmem_q.result,
                         ld_data: '0, dest: exmem_q.dest, flags: exmem_q.flags};
      end
   end

   assign dmem_addr  = exmem_q.result[7:0];
   // A store behind a taken branch is flushed before it writes
   assign dmem_we    = exmem_q.valid && exmem_q.ctrl.mem_we && !halted && !take_branch;
   assign dmem_wdata = exmem_q.store_data;

   assign wb_data   = (wb_s.ctrl.wb_sel == pipe_pkg::WB_MEM) ? wb_s.ld_data : wb_s.result;
   assign wb_we     = wb_s.valid && wb_s.ctrl.reg_we && !halted;
   assign out_valid = wb_s.valid && wb_s.ctrl.out_en && !halted;
   assign out_data  = wb_s.result;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         flags_q <= '0;
         halted  <= 1'b0;
      end else if (wb_s.valid && !halted) begin
         if (wb_s.ctrl.set_flags)
            flags_q <= wb_s.flags;
         if (wb_s.ctrl.halt)
            halted <= 1'b1;   // Sticky until reset
      end
   end

endmodule

/* hw/word_ram.sv */
`timescale 1ns/1ps

module word_ram (
   input  logic                      clk,
   input  logic                      we,
   input  logic [isa_pkg::ADDR_W-1:0] wr_addr,
   input  isa_pkg::word_t            wr_data,
   input  logic [isa_pkg::ADDR_W-1:0] rd_addr,
   output isa_pkg::word_t            rd_data
);

   isa_pkg::word_t mem [isa_pkg::MEM_DEPTH];

   always_ff @(posedge clk) begin
      if (we)
         mem[wr_addr] <= wr_data;
      rd_data <= mem[rd_addr];   // Old data on a same-address write
   end

endmodule

/* hw/pipe_controller.sv */
`timescale 1ns/1ps

module pipe_controller (
   input  isa_pkg::word_t                 inst,
   input  logic                           id_valid,
   input  logic [isa_pkg::NUM_REGS-1:0]   pending,
   input  isa_pkg::cond_e                 wb_cond,
   input  isa_pkg::flags_t                flags,
   output pipe_pkg::ctrl_t                ctrl,
   output logic                           en_ifid,
   output logic                           flush_ifid,
   output logic                           en_idex,
   output logic                           flush_idex,
   output logic                           en_exmem,
   output logic                           flush_exmem,
   output logic                           en_memwb,
   output logic                           flush_memwb,
   output logic                           pc_en,
   output logic                           take_branch
);

   isa_pkg::op_e     op;
   isa_pkg::reg_idx_t ra;
   isa_pkg::reg_idx_t rb;
   isa_pkg::reg_idx_t dest;
   isa_pkg::alu_fn_e fn;
   pipe_pkg::ctrl_t  dec;
   logic             data_hazard;

   assign op   = isa_pkg::op_e'(inst[15:14]);
   assign ra   = inst[13:11];
   assign rb   = inst[10:8];
   assign fn   = isa_pkg::alu_fn_e'(inst[7:4]);
   assign dest = dec.dest_is_ra ? ra : rb;

   always_comb begin
      dec = '{reg_we: 1'b0, dest_is_ra: 1'b0, mem_we: 1'b0, out_en: 1'b0, halt: 1'b0,
              cond: isa_pkg::COND_NONE, alu_fn: isa_pkg::FN_ADD,
              src_a: pipe_pkg::A_ZERO, src_b: pipe_pkg::B_ONE,
              wb_sel: pipe_pkg::WB_ALU, set_flags: 1'b0};
      if (id_valid) begin
         case (op)
            isa_pkg::OP_LD: begin
               dec.reg_we     = 1'b1;
               dec.dest_is_ra = 1'b1;
               dec.src_a      = pipe_pkg::A_REG_RB;
               dec.src_b      = pipe_pkg::B_IMM;
               dec.wb_sel     = pipe_pkg::WB_MEM;
            end
            isa_pkg::OP_ST: begin
               dec.mem_we = 1'b1;
               dec.src_a  = pipe_pkg::A_REG_RB;
               dec.src_b  = pipe_pkg::B_IMM;
            end
            isa_pkg::OP_IMM: begin
               if (ra == 3'd0) begin   // LI
                  dec.reg_we = 1'b1;
                  dec.wb_sel = pipe_pkg::WB_IMM;
               end else if (ra == 3'd4 || ra == 3'd7) begin
                  dec.src_a = pipe_pkg::A_PC;
                  dec.src_b = pipe_pkg::B_IMM;
                  if (ra == 3'd4) begin
                     dec.cond = isa_pkg::COND_B;
                  end else begin
                     case (rb)
                        3'd0:    dec.cond = isa_pkg::COND_BE;
                        3'd1:    dec.cond = isa_pkg::COND_BLT;
                        3'd2:    dec.cond = isa_pkg::COND_BLE;
                        3'd3:    dec.cond = isa_pkg::COND_BNE;
                        default: dec.cond = isa_pkg::COND_NONE;
                     endcase
                  end
               end
            end
            default: begin
               dec.alu_fn = fn;
               case (fn)
                  isa_pkg::FN_ADD, isa_pkg::FN_SUB, isa_pkg::FN_AND,
                  isa_pkg::FN_OR, isa_pkg::FN_XOR, isa_pkg::FN_CMP: begin
                     dec.reg_we    = (fn != isa_pkg::FN_CMP);
                     dec.src_a     = pipe_pkg::A_REG_RB;
                     dec.src_b     = pipe_pkg::B_REG_RA;
                     dec.set_flags = 1'b1;
                  end
                  isa_pkg::FN_MOV: begin
                     dec.reg_we = 1'b1;
                     dec.src_b  = pipe_pkg::B_REG_RA;
                  end
                  isa_pkg::FN_SLL, isa_pkg::FN_SLR, isa_pkg::FN_SRL, isa_pkg::FN_SRA: begin
                     dec.reg_we    = 1'b1;
                     dec.src_a     = pipe_pkg::A_REG_RB;
                     dec.src_b     = pipe_pkg::B_SHAMT;
                     dec.set_flags = 1'b1;
                  end
                  isa_pkg::FN_OUT: begin
                     dec.out_en = 1'b1;
                     dec.src_a  = pipe_pkg::A_REG_RB;
                     dec.wb_sel = pipe_pkg::WB_PASS_A;
                  end
                  isa_pkg::FN_HLT: dec.halt = 1'b1;
                  default: ;   // IN and unused codes
               endcase
            end
         endcase
      end
   end

   // Destination check too, so an older write cannot clear a newer mark
   assign data_hazard = id_valid &&
      ((dec.src_a == pipe_pkg::A_REG_RB && pending[rb]) ||
       (dec.src_b == pipe_pkg::B_REG_RA && pending[ra]) ||
       (dec.mem_we && pending[ra]) ||
       (dec.reg_we && pending[dest]));

   assign ctrl = dec;

   always_comb begin
      case (wb_cond)
         isa_pkg::COND_B:   take_branch = 1'b1;
         isa_pkg::COND_BE:  take_branch = flags.z;
         isa_pkg::COND_BLT: take_branch = flags.s ^ flags.v;
         isa_pkg::COND_BLE: take_branch = flags.z | (flags.s ^ flags.v);
         isa_pkg::COND_BNE: take_branch = !flags.z;
         default:           take_branch = 1'b0;
      endcase
   end

   always_comb begin
      en_ifid     = 1'b1;
      flush_ifid  = 1'b0;
      en_idex     = 1'b1;
      flush_idex  = 1'b0;
      en_exmem    = 1'b1;
      flush_exmem = 1'b0;
      en_memwb    = 1'b1;
      flush_memwb = 1'b0;
      pc_en       = 1'b1;
      if (take_branch) begin
         flush_ifid  = 1'b1;
         flush_idex  = 1'b1;
         flush_exmem = 1'b1;
         flush_memwb = 1'b1;
      end else if (data_hazard) begin
         pc_en      = 1'b0;
         en_ifid    = 1'b0;
         flush_idex = 1'b1;   // Bubble into EX, which also drops a stalled OUT
      end
   end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         flush_all,
   input  isa_pkg::reg_idx_t            rd_a_idx,
   input  isa_pkg::reg_idx_t            rd_b_idx,
   input  logic                         we,
   input  isa_pkg::reg_idx_t            wr_idx,
   input  isa_pkg::word_t               wr_data,
   input  logic                         mark_en,
   input  isa_pkg::reg_idx_t            mark_idx,
   output isa_pkg::word_t               rd_a,
   output isa_pkg::word_t               rd_b,
   output logic [isa_pkg::NUM_REGS-1:0] pending
);

   isa_pkg::word_t                 regs [isa_pkg::NUM_REGS];
   logic [isa_pkg::NUM_REGS-1:0]   pend_q;
   logic [isa_pkg::NUM_REGS-1:0]   clr_mask;
   logic [isa_pkg::NUM_REGS-1:0]   set_mask;

   assign clr_mask = we ? (isa_pkg::NUM_REGS'(1) << wr_idx) : '0;
   assign set_mask = mark_en ? (isa_pkg::NUM_REGS'(1) << mark_idx) : '0;

   always_ff @(posedge clk) begin
      if (we)
         regs[wr_idx] <= wr_data;
   end

   always_ff @(posedge clk) begin
      if (!rst_n || flush_all)
         pend_q <= '0;
      else
         pend_q <= (pend_q & ~clr_mask) | set_mask;   // Set wins
   end

   // Clears in the write cycle so ID can read through
   assign pending = pend_q & ~clr_mask;

   assign rd_a = (we && wr_idx == rd_a_idx) ? wr_data : regs[rd_a_idx];
   assign rd_b = (we && wr_idx == rd_b_idx) ? wr_data : regs[rd_b_idx];

endmodule

/* hw/alu.sv */
`timescale 1ns/1ps

module alu (
   input  isa_pkg::alu_fn_e fn,
   input  isa_pkg::word_t   a,
   input  isa_pkg::word_t   b,
   output isa_pkg::word_t   y,
   output isa_pkg::flags_t  flags
);

   logic [16:0] wide;
   logic [3:0]  sh;
   logic        carry;
   logic        ovf;

   assign sh = b[3:0];

   always_comb begin
      wide  = '0;
      carry = 1'b0;
      ovf   = 1'b0;
      case (fn)
         isa_pkg::FN_ADD: begin
            wide  = {1'b0, a} + {1'b0, b};
            carry = wide[16];
            ovf   = (a[15] == b[15]) && (wide[15] != a[15]);
         end
         isa_pkg::FN_SUB, isa_pkg::FN_CMP: begin
            wide  = {1'b0, a} - {1'b0, b};
            carry = wide[16];   // Borrow
            ovf   = (a[15] != b[15]) && (wide[15] != a[15]);
         end
         isa_pkg::FN_AND: wide[15:0] = a & b;
         isa_pkg::FN_OR:  wide[15:0] = a | b;
         isa_pkg::FN_XOR: wide[15:0] = a ^ b;
         isa_pkg::FN_MOV: wide[15:0] = b;
         isa_pkg::FN_SLL: begin
            wide  = {1'b0, a} << sh;
            carry = wide[16];
         end
         isa_pkg::FN_SLR: wide[15:0] = (a << sh) | (a >> (5'd16 - {1'b0, sh}));
         isa_pkg::FN_SRL: begin
            wide[15:0] = a >> sh;
            carry      = (sh != 4'd0) ? a[sh - 4'd1] : 1'b0;
         end
         isa_pkg::FN_SRA: begin
            wide[15:0] = $signed(a) >>> sh;
            carry      = (sh != 4'd0) ? a[sh - 4'd1] : 1'b0;
         end
         default: wide[15:0] = a;
      endcase
   end

   assign y     = wide[15:0];
   assign flags = '{s: y[15], z: (y == '0), c: carry, v: ovf};

endmodule

/* hw/pipe_pkg.sv */
package pipe_pkg;

   typedef enum logic [1:0] {
      A_REG_RB = 2'd0,
      A_PC     = 2'd1,
      A_ZERO   = 2'd2
   } src_a_e;

   typedef enum logic [1:0] {
      B_REG_RA = 2'd0,
      B_SHAMT  = 2'd1,   // d[3:0]
      B_IMM    = 2'd2,
      B_ONE    = 2'd3
   } src_b_e;

   typedef enum logic [1:0] {
      WB_ALU    = 2'd0,
      WB_PASS_A = 2'd1,
      WB_MEM    = 2'd2,
      WB_IMM    = 2'd3
   } wb_sel_e;

   typedef struct packed {
      logic             reg_we;
      logic             dest_is_ra;
      logic             mem_we;
      logic             out_en;
      logic             halt;
      isa_pkg::cond_e   cond;
      isa_pkg::alu_fn_e alu_fn;
      src_a_e           src_a;
      src_b_e           src_b;
      wb_sel_e          wb_sel;
      logic             set_flags;
   } ctrl_t;

   typedef struct packed {
      logic           valid;
      isa_pkg::word_t pc;
      isa_pkg::word_t inst;
   } ifid_t;

   typedef struct packed {
      logic              valid;
      isa_pkg::word_t    pc;     // Address after the instruction
      ctrl_t             ctrl;
      isa_pkg::word_t    op_a;
      isa_pkg::word_t    op_b;
      isa_pkg::word_t    imm;
      isa_pkg::reg_idx_t dest;
   } idex_t;

   typedef struct packed {
      logic              valid;
      ctrl_t             ctrl;
      isa_pkg::word_t    result;
      isa_pkg::word_t    store_data;
      isa_pkg::reg_idx_t dest;
      isa_pkg::flags_t   flags;
   } exmem_t;

   typedef struct packed {
      logic              valid;
      ctrl_t             ctrl;
      isa_pkg::word_t    result;
      isa_pkg::word_t    ld_data;
      isa_pkg::reg_idx_t dest;
      isa_pkg::flags_t   flags;
   } memwb_t;

endpackage

/* hw/isa_pkg.sv */
package isa_pkg;

   localparam int WORD_W    = 16;
   localparam int ADDR_W    = 8;
   localparam int MEM_DEPTH = 1 << ADDR_W;
   localparam int NUM_REGS  = 8;

   typedef logic [WORD_W-1:0]           word_t;
   typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

   typedef enum logic [1:0] {
      OP_LD  = 2'd0,
      OP_ST  = 2'd1,
      OP_IMM = 2'd2,   // LI and branches
      OP_ALU = 2'd3
   } op_e;

   typedef enum logic [3:0] {
      FN_ADD = 4'd0,  FN_SUB = 4'd1,  FN_AND = 4'd2,  FN_OR   = 4'd3,
      FN_XOR = 4'd4,  FN_CMP = 4'd5,  FN_MOV = 4'd6,  FN_RSV7 = 4'd7,
      FN_SLL = 4'd8,  FN_SLR = 4'd9,  FN_SRL = 4'd10, FN_SRA  = 4'd11,
      FN_IN  = 4'd12, FN_OUT = 4'd13, FN_RSV14 = 4'd14, FN_HLT = 4'd15
   } alu_fn_e;

   typedef enum logic [2:0] {
      COND_NONE = 3'd0,
      COND_B    = 3'd1,
      COND_BE   = 3'd2,
      COND_BLT  = 3'd3,
      COND_BLE  = 3'd4,
      COND_BNE  = 3'd5
   } cond_e;

   typedef struct packed {
      logic s;
      logic z;
      logic c;
      logic v;
   } flags_t;

endpackage
